// ==== all.f ====
+incdir+design
design/fe_pkg.sv
design/fetch_unit.sv
design/instr_buffer.sv
design/decode_unit.sv
design/frontend_top.sv
dv/fe_checker.sv
dv/tb_top.sv

// ==== design/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module decode_unit
    import fe_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush_i,
    // Downstream capacity this cycle
    input  logic [$clog2(`FE_ID_WIDTH+1)-1:0]   issue_slots_i,
    // Buffer head
    input  logic [`FE_ID_WIDTH-1:0]             head_valid_i,
    input  logic [`FE_XLEN-1:0]                 head_pc_i[`FE_ID_WIDTH],
    input  logic [`FE_XLEN-1:0]                 head_instr_i[`FE_ID_WIDTH],
    output logic [`FE_ID_WIDTH-1:0]             accept_o,
    // Registered decode results
    output logic [`FE_ID_WIDTH-1:0]             dec_valid_o,
    output logic [`FE_XLEN-1:0]                 dec_pc_o[`FE_ID_WIDTH],
    output op_class_e                           dec_op_o[`FE_ID_WIDTH],
    output logic [4:0]                          dec_rd_o[`FE_ID_WIDTH]
);

    localparam int SLOT_W = $clog2(`FE_ID_WIDTH + 1);

    // RV32 major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic [SLOT_W-1:0] head_num;
    logic [SLOT_W-1:0] take_num;
    op_class_e         op_class[`FE_ID_WIDTH];
    logic [4:0]        rd_field[`FE_ID_WIDTH];

    function automatic op_class_e classify(input logic [6:0] opcode);
        op_class_e cls;
        case (opcode)
            OPC_OP, OPC_OP_IMM: cls = OP_ALU;
            OPC_LOAD:           cls = OP_LOAD;
            OPC_STORE:          cls = OP_STORE;
            OPC_BRANCH:         cls = OP_BRANCH;
            OPC_JAL, OPC_JALR:  cls = OP_JUMP;
            default:            cls = OP_OTHER;
        endcase
        return cls;
    endfunction

    // Head valid bits are a prefix
    always_comb begin
        head_num = '0;
        for (int i = 0; i < `FE_ID_WIDTH; i++) begin
            head_num = head_num + SLOT_W'(head_valid_i[i]);
        end
    end

    assign take_num = (issue_slots_i < head_num) ? issue_slots_i : head_num;

    for (genvar i = 0; i < `FE_ID_WIDTH; i++) begin : g_slot
        assign accept_o[i] = SLOT_W'(i) < take_num;
        assign op_class[i] = classify(head_instr_i[i][6:0]);
        // S and B formats reuse bits 11:7 for the immediate
        assign rd_field[i] = (op_class[i] == OP_STORE || op_class[i] == OP_BRANCH) ?
                             5'd0 : head_instr_i[i][11:7];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid_o <= '0;
        end else if (flush_i) begin
            dec_valid_o <= '0;
        end else begin
            dec_valid_o <= accept_o;
        end
    end

    // Payload only moves on accept
    always_ff @(posedge clk) begin
        for (int i = 0; i < `FE_ID_WIDTH; i++) begin
            if (accept_o[i]) begin
                dec_pc_o[i] <= head_pc_i[i];
                dec_op_o[i] <= op_class[i];
                dec_rd_o[i] <= rd_field[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fe_defines.svh ====
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// Instructions fetched per cycle
`define FE_IF_WIDTH 2

// Instructions decoded per cycle
`define FE_ID_WIDTH 2

// Buffer entries, power of two
`define FE_BUFFER_SIZE 8

// PC and instruction word width
`define FE_XLEN 32

// Fetch stalls at or below this many free entries
// Equal to the fetch width so one full group always fits
`define FE_STALL_MARGIN `FE_IF_WIDTH

`endif

// ==== design/fe_pkg.sv ====
`default_nettype none

package fe_pkg;

    // Major opcode class of a decoded instruction
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,
        OP_BRANCH = 3'd3,
        OP_JUMP   = 3'd4,
        OP_OTHER  = 3'd5
    } op_class_e;

    // Fetch controller
    // REDIRECT lasts one cycle after a flush
    typedef enum logic [1:0] {
        FETCH_RUN      = 2'd0,
        FETCH_STALL    = 2'd1,
        FETCH_REDIRECT = 2'd2
    } fetch_state_e;

endpackage

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module fetch_unit
    import fe_pkg::*;
#(
    parameter logic [`FE_XLEN-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // Control from buffer and backend
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic [`FE_XLEN-1:0]     redirect_pc_i,
    // Instruction memory
    output logic [`FE_XLEN-1:0]     imem_addr_o,
    input  logic [`FE_XLEN-1:0]     imem_rdata_i[`FE_IF_WIDTH],
    // Fetch group to buffer
    output logic [`FE_IF_WIDTH-1:0] fetch_valid_o,
    output logic [`FE_XLEN-1:0]     fetch_pc_o[`FE_IF_WIDTH],
    output logic [`FE_XLEN-1:0]     fetch_instr_o[`FE_IF_WIDTH]
);

    // Bytes covered by one fetch group
    localparam logic [`FE_XLEN-1:0] GROUP_BYTES = `FE_XLEN'(`FE_IF_WIDTH * 4);

    fetch_state_e        state_q;
    fetch_state_e        state_d;
    logic [`FE_XLEN-1:0] pc_q;
    logic [`FE_XLEN-1:0] pc_d;
    logic                fetch_go;

    always_comb begin
        state_d  = state_q;
        pc_d     = pc_q;
        fetch_go = 1'b0;
        if (flush_i) begin
            // Group in flight is dropped, restart at the target
            state_d = FETCH_REDIRECT;
            pc_d    = redirect_pc_i;
        end else begin
            case (state_q)
                FETCH_RUN, FETCH_REDIRECT: begin
                    if (stall_i) begin
                        state_d = FETCH_STALL;
                    end else begin
                        fetch_go = 1'b1;
                        state_d  = FETCH_RUN;
                    end
                end
                FETCH_STALL: begin
                    // Wait one bubble after the buffer drains
                    if (!stall_i) begin
                        state_d = FETCH_RUN;
                    end
                end
                default: begin
                    state_d = FETCH_RUN;
                end
            endcase
            if (fetch_go) begin
                pc_d = pc_q + GROUP_BYTES;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= FETCH_RUN;
            pc_q    <= RESET_PC;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    assign imem_addr_o = pc_q;

    // Memory returns PC, PC+4, ... in slot order
    for (genvar i = 0; i < `FE_IF_WIDTH; i++) begin : g_slot
        assign fetch_valid_o[i] = fetch_go;
        assign fetch_pc_o[i]    = pc_q + `FE_XLEN'(i * 4);
        assign fetch_instr_o[i] = imem_rdata_i[i];
    end

endmodule

`default_nettype wire

// ==== design/frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module frontend_top
    import fe_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    // Mispredict redirect and downstream capacity
    input  logic                                flush_i,
    input  logic [`FE_XLEN-1:0]                 redirect_pc_i,
    input  logic [$clog2(`FE_ID_WIDTH+1)-1:0]   issue_slots_i,
    // Instruction memory
    output logic [`FE_XLEN-1:0]                 imem_addr_o,
    input  logic [`FE_XLEN-1:0]                 imem_rdata_i[`FE_IF_WIDTH],
    // Decoded slots
    output logic [`FE_ID_WIDTH-1:0]             dec_valid_o,
    output logic [`FE_XLEN-1:0]                 dec_pc_o[`FE_ID_WIDTH],
    output op_class_e                           dec_op_o[`FE_ID_WIDTH],
    output logic [4:0]                          dec_rd_o[`FE_ID_WIDTH]
);

    logic [`FE_IF_WIDTH-1:0] fetch_valid;
    logic [`FE_XLEN-1:0]     fetch_pc[`FE_IF_WIDTH];
    logic [`FE_XLEN-1:0]     fetch_instr[`FE_IF_WIDTH];
    logic                    buf_stall;
    logic [`FE_ID_WIDTH-1:0] head_valid;
    logic [`FE_XLEN-1:0]     head_pc[`FE_ID_WIDTH];
    logic [`FE_XLEN-1:0]     head_instr[`FE_ID_WIDTH];
    logic [`FE_ID_WIDTH-1:0] dec_accept;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_i       (buf_stall),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .fetch_valid_o (fetch_valid),
        .fetch_pc_o    (fetch_pc),
        .fetch_instr_o (fetch_instr)
    );

    instr_buffer u_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid),
        .fetch_pc_i    (fetch_pc),
        .fetch_instr_i (fetch_instr),
        .stall_o       (buf_stall),
        .head_valid_o  (head_valid),
        .head_pc_o     (head_pc),
        .head_instr_o  (head_instr),
        .accept_i      (dec_accept)
    );

    decode_unit u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .issue_slots_i (issue_slots_i),
        .head_valid_i  (head_valid),
        .head_pc_i     (head_pc),
        .head_instr_i  (head_instr),
        .accept_o      (dec_accept),
        .dec_valid_o   (dec_valid_o),
        .dec_pc_o      (dec_pc_o),
        .dec_op_o      (dec_op_o),
        .dec_rd_o      (dec_rd_o)
    );

endmodule

`default_nettype wire

// ==== design/instr_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module instr_buffer #(
    parameter int IF_WIDTH    = `FE_IF_WIDTH,
    parameter int ID_WIDTH    = `FE_ID_WIDTH,
    parameter int BUFFER_SIZE = `FE_BUFFER_SIZE
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_i,
    // Fetch side
    input  logic [IF_WIDTH-1:0] fetch_valid_i,
    input  logic [`FE_XLEN-1:0] fetch_pc_i[IF_WIDTH],
    input  logic [`FE_XLEN-1:0] fetch_instr_i[IF_WIDTH],
    output logic                stall_o,
    // Decode side, slot 0 is the oldest entry
    output logic [ID_WIDTH-1:0] head_valid_o,
    output logic [`FE_XLEN-1:0] head_pc_o[ID_WIDTH],
    output logic [`FE_XLEN-1:0] head_instr_o[ID_WIDTH],
    input  logic [ID_WIDTH-1:0] accept_i
);

    localparam int PTR_W  = $clog2(BUFFER_SIZE);
    localparam int CNT_W  = $clog2(BUFFER_SIZE + 1);
    localparam int PUSH_W = $clog2(IF_WIDTH + 1);
    localparam int POP_W  = $clog2(ID_WIDTH + 1);

    // Entry storage
    logic [`FE_XLEN-1:0] pc_mem[BUFFER_SIZE];
    logic [`FE_XLEN-1:0] instr_mem[BUFFER_SIZE];

    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  free_cnt;
    logic [PUSH_W-1:0] push_num;
    logic [POP_W-1:0]  pop_num;
    logic [PTR_W-1:0]  wr_idx[IF_WIDTH];
    logic [PTR_W-1:0]  rd_idx[ID_WIDTH];

    // Incoming valid bits form a prefix, so the count is the write span
    always_comb begin
        push_num = '0;
        for (int i = 0; i < IF_WIDTH; i++) begin
            push_num = push_num + PUSH_W'(fetch_valid_i[i]);
        end
    end

    always_comb begin
        pop_num = '0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            pop_num = pop_num + POP_W'(accept_i[i]);
        end
    end

    // Slot indices wrap with the pointer width
    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            wr_idx[i] = wr_ptr + PTR_W'(i);
        end
        for (int i = 0; i < ID_WIDTH; i++) begin
            rd_idx[i] = rd_ptr + PTR_W'(i);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            if (fetch_valid_i[i] && !flush_i) begin
                pc_mem[wr_idx[i]]    <= fetch_pc_i[i];
                instr_mem[wr_idx[i]] <= fetch_instr_i[i];
            end
        end
    end

    // Explicit count tells full from empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(pop_num);
            wr_ptr <= wr_ptr + PTR_W'(push_num);
            count  <= count + CNT_W'(push_num) - CNT_W'(pop_num);
        end
    end

    assign free_cnt = CNT_W'(BUFFER_SIZE) - count;
    assign stall_o  = free_cnt <= CNT_W'(`FE_STALL_MARGIN);

    for (genvar i = 0; i < ID_WIDTH; i++) begin : g_head
        assign head_valid_o[i] = CNT_W'(i) < count;
        assign head_pc_o[i]    = pc_mem[rd_idx[i]];
        assign head_instr_o[i] = instr_mem[rd_idx[i]];
    end

endmodule

`default_nettype wire

// ==== dv/fe_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_checker #(
    parameter int IF_WIDTH    = 2,
    parameter int ID_WIDTH    = 2,
    parameter int BUFFER_SIZE = 8
) (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             flush_i,
    input logic [IF_WIDTH-1:0]              fetch_valid_i,
    input logic                             stall_i,
    input logic [ID_WIDTH-1:0]              head_valid_i,
    input logic [ID_WIDTH-1:0]              accept_i,
    input logic [$clog2(BUFFER_SIZE+1)-1:0] count_i
);

    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    occupancy_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) count_i <= CNT_W'(BUFFER_SIZE)
    ) else $error("occupancy %0d exceeds %0d entries", count_i, BUFFER_SIZE);

    // Fetch holds off while the buffer reports stall
    no_write_when_stalled: assert property (
        @(posedge clk) disable iff (!rst_n) stall_i |-> fetch_valid_i == '0
    ) else $error("fetch write while stall is high");

    // Accepted slots form a prefix inside the valid head entries
    accept_is_prefix: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((accept_i & ~head_valid_i) == '0) && ((accept_i & (accept_i + ID_WIDTH'(1))) == '0)
    ) else $error("accept %b is not a prefix of head valid %b", accept_i, head_valid_i);

    flush_empties_buffer: assert property (
        @(posedge clk) disable iff (!rst_n) flush_i |=> count_i == '0
    ) else $error("buffer not empty the cycle after a flush");

endmodule

bind instr_buffer fe_checker #(
    .IF_WIDTH    (IF_WIDTH),
    .ID_WIDTH    (ID_WIDTH),
    .BUFFER_SIZE (BUFFER_SIZE)
) u_fe_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .stall_i       (stall_o),
    .head_valid_i  (head_valid_o),
    .accept_i      (accept_i),
    .count_i       (count)
);

`default_nettype wire

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module tb_top
    import fe_pkg::*;
();

    localparam int MEM_WORDS    = 256;
    localparam int RESET_CYCLES = 5;
    // Cycle budget of all six tests together
    localparam int TEST_CYCLES  = 700;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                    clk;
    logic                    rst_n;
    logic                    flush;
    logic [31:0]             redirect_pc;
    logic [1:0]              issue_slots;
    logic [31:0]             imem_addr;
    logic [31:0]             imem_rdata[`FE_IF_WIDTH];
    logic [`FE_ID_WIDTH-1:0] dec_valid;
    logic [31:0]             dec_pc[`FE_ID_WIDTH];
    op_class_e               dec_op[`FE_ID_WIDTH];
    logic [4:0]              dec_rd[`FE_ID_WIDTH];

    logic [31:0] imem[MEM_WORDS];
    op_class_e   exp_op[MEM_WORDS];
    logic [4:0]  exp_rd[MEM_WORDS];
    logic [31:0] lfsr_state;

    // Reference model state
    logic [31:0] exp_pc;
    logic [1:0]  prev_slots;
    logic        flush_seen;
    logic        post_flush_got;
    logic [31:0] post_flush_pc;
    int          dec_total;
    int          flush_count;
    int          errors;

    frontend_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush),
        .redirect_pc_i (redirect_pc),
        .issue_slots_i (issue_slots),
        .imem_addr_o   (imem_addr),
        .imem_rdata_i  (imem_rdata),
        .dec_valid_o   (dec_valid),
        .dec_pc_o      (dec_pc),
        .dec_op_o      (dec_op),
        .dec_rd_o      (dec_rd)
    );

    always #50 clk = ~clk;

    // Combinational memory, word index wraps at 1 KB
    for (genvar i = 0; i < `FE_IF_WIDTH; i++) begin : g_imem
        assign imem_rdata[i] = imem[imem_addr[9:2] + 8'(i)];
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [1:0] random_slots();
        logic [7:0] r;
        r = rand_bits(2);
        return (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // Class mixes all address bits; rd holds the low index bits
    task automatic fill_memory();
        logic [7:0] idx;
        logic [6:0] opc;
        int sel;
        for (int a = 0; a < MEM_WORDS; a++) begin
            idx = 8'(a);
            sel = int'(idx ^ (idx >> 3) ^ (idx >> 6)) % 6;
            case (sel)
                0: begin
                    opc = idx[0] ? 7'b0010011 : 7'b0110011;
                    exp_op[a] = OP_ALU;
                end
                1: begin
                    opc = 7'b0000011;
                    exp_op[a] = OP_LOAD;
                end
                2: begin
                    opc = 7'b0100011;
                    exp_op[a] = OP_STORE;
                end
                3: begin
                    opc = 7'b1100011;
                    exp_op[a] = OP_BRANCH;
                end
                4: begin
                    opc = idx[1] ? 7'b1100111 : 7'b1101111;
                    exp_op[a] = OP_JUMP;
                end
                default: begin
                    opc = idx[2] ? 7'b0010111 : 7'b0110111;
                    exp_op[a] = OP_OTHER;
                end
            endcase
            // Store and branch have no destination register
            exp_rd[a] = (sel == 2 || sel == 3) ? 5'd0 : idx[4:0];
            imem[a] = {idx, 4'h0, 5'd0, 3'b000, idx[4:0], opc};
        end
    endtask

    task automatic wait_decoded(input int target, input int limit);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (dec_total < target && n < limit);
        if (dec_total < target) begin
            note_failure($sformatf("timeout: %0d of %0d instructions decoded", dec_total, target));
        end
    endtask

    task automatic test_reset_state();
        int wait_cycles;
        @(negedge clk);
        if (dec_valid !== '0) report_mismatch("dec_valid_o", 32'(dec_valid), 32'h0);
        if (imem_addr !== 32'h0) report_mismatch("imem_addr_o", imem_addr, 32'h0);
        if (dut_i.buf_stall !== 1'b0) report_mismatch("buf_stall", 32'(dut_i.buf_stall), 32'h0);
        wait_cycles = 0;
        while (dec_valid == '0 && wait_cycles < 10) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (dec_valid !== 2'b11) begin
            report_mismatch("dec_valid_o", 32'(dec_valid), 32'h3);
        end else begin
            if (dec_pc[0] !== 32'h0) report_mismatch("dec_pc_o[0]", dec_pc[0], 32'h0);
            if (dec_pc[1] !== 32'h4) report_mismatch("dec_pc_o[1]", dec_pc[1], 32'h4);
            if (wait_cycles != 2) note_failure($sformatf("decode latency %0d, not 2", wait_cycles));
        end
    endtask

    task automatic test_streaming();
        int start;
        int bubbles;
        @(posedge clk);
        issue_slots <= 2'd2;
        start = dec_total;
        bubbles = 0;
        repeat (16) begin
            @(negedge clk);
            if (dec_valid !== 2'b11) bubbles++;
        end
        if (bubbles != 0) note_failure($sformatf("%0d bubbles at full rate", bubbles));
        wait_decoded(start + 32, 40);
    endtask

    task automatic test_backpressure();
        int start;
        @(posedge clk);
        issue_slots <= 2'd0;
        repeat (30) @(posedge clk);
        @(negedge clk);
        if (dec_valid !== '0) report_mismatch("dec_valid_o", 32'(dec_valid), 32'h0);
        if (dut_i.buf_stall !== 1'b1) note_failure("buffer did not stall under back-pressure");
        @(posedge clk);
        start = dec_total;
        issue_slots <= 2'd2;
        wait_decoded(start + 40, 60);
    endtask

    task automatic test_random_slots();
        int start;
        @(posedge clk);
        start = dec_total;
        for (int c = 0; c < 120; c++) begin
            issue_slots <= random_slots();
            @(posedge clk);
        end
        issue_slots <= 2'd2;
        wait_decoded(start + 60, 60);
    endtask

    task automatic test_flush();
        logic [31:0] target;
        int n;
        for (int k = 0; k < 2; k++) begin
            target = (k == 0) ? 32'h200 : 32'h84;
            @(posedge clk);
            issue_slots <= (k == 0) ? 2'd2 : 2'd0;
            repeat (12) @(posedge clk);
            flush <= 1'b1;
            redirect_pc <= target;
            flush_count++;
            @(posedge clk);
            flush <= 1'b0;
            issue_slots <= 2'd2;
            @(negedge clk);
            if (imem_addr !== target) report_mismatch("imem_addr_o", imem_addr, target);
            if (dec_valid !== '0) report_mismatch("dec_valid_o", 32'(dec_valid), 32'h0);
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (!post_flush_got && n < 10);
            if (!post_flush_got) begin
                note_failure("no instruction decoded after the flush");
            end else if (post_flush_pc !== target) begin
                report_mismatch("dec_pc_o after flush", post_flush_pc, target);
            end
        end
    endtask

    task automatic test_random_flush();
        logic [7:0] pick;
        logic [7:0] addr_bits;
        int start;
        @(posedge clk);
        for (int c = 0; c < 150; c++) begin
            issue_slots <= random_slots();
            pick = rand_bits(3);
            if (pick == 8'd0 || c % 40 == 39) begin
                addr_bits = rand_bits(8);
                flush <= 1'b1;
                redirect_pc <= {22'd0, addr_bits, 2'b00};
                flush_count++;
            end else begin
                flush <= 1'b0;
            end
            @(posedge clk);
        end
        flush <= 1'b0;
        issue_slots <= 2'd2;
        start = dec_total;
        wait_decoded(start + 20, 40);
    endtask

    // Decoded slots in order must follow the expected PC stream
    always @(negedge clk) begin : monitor
        int nvalid;
        logic [7:0] idx;
        if (!rst_n) begin
            exp_pc = '0;
            prev_slots = '0;
            flush_seen = 1'b0;
            post_flush_got = 1'b0;
            post_flush_pc = '0;
            dec_total = 0;
        end else begin
            nvalid = 0;
            for (int i = 0; i < `FE_ID_WIDTH; i++) begin
                nvalid += int'(dec_valid[i]);
            end
            if ((dec_valid & (dec_valid + 2'd1)) != '0) begin
                note_failure($sformatf("dec_valid_o %b is not a prefix", dec_valid));
            end
            if (nvalid > int'(prev_slots)) begin
                note_failure($sformatf("%0d decoded with %0d slots granted", nvalid, prev_slots));
            end
            for (int i = 0; i < `FE_ID_WIDTH; i++) begin
                if (dec_valid[i]) begin
                    if (dec_pc[i] !== exp_pc) begin
                        report_mismatch($sformatf("dec_pc_o[%0d]", i), dec_pc[i], exp_pc);
                        // Resync to limit follow-on errors
                        exp_pc = dec_pc[i];
                    end
                    idx = exp_pc[9:2];
                    if (dec_op[i] !== exp_op[idx]) begin
                        report_mismatch($sformatf("dec_op_o[%0d]", i), 32'(dec_op[i]),
                                        32'(exp_op[idx]));
                    end
                    if (dec_rd[i] !== exp_rd[idx]) begin
                        report_mismatch($sformatf("dec_rd_o[%0d]", i), 32'(dec_rd[i]),
                                        32'(exp_rd[idx]));
                    end
                    if (flush_seen) begin
                        post_flush_pc = dec_pc[i];
                        post_flush_got = 1'b1;
                        flush_seen = 1'b0;
                    end
                    exp_pc = exp_pc + 32'd4;
                    dec_total++;
                end
            end
            if (flush) begin
                exp_pc = redirect_pc;
                flush_seen = 1'b1;
                post_flush_got = 1'b0;
            end
            prev_slots = issue_slots;
        end
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        redirect_pc = '0;
        issue_slots = 2'd2;
        lfsr_state = 32'd84191;
        errors = 0;
        flush_count = 0;
        fill_memory();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_streaming();
        test_backpressure();
        test_random_slots();
        test_flush();
        test_random_flush();
        repeat (4) @(posedge clk);
        $display("errors: %0d, decoded: %0d, flushes: %0d", errors, dec_total, flush_count);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((RESET_CYCLES + TEST_CYCLES) * 100 + 2000);
        $display("watchdog expired before the tests completed");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -f all.f --top-module tb_top -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0
